//--- common/mcalc_pkg.sv
package mcalc_pkg;

    localparam int DIM_W   = 3;
    localparam int MAX_DIM = 5;
    localparam int ADDR_W  = 9;
    localparam int IDX_W   = 5;    // caps the ledger at 32 types

    typedef logic [DIM_W-1:0]  dim_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [IDX_W-1:0]  idx_t;
    typedef logic [1:0]        cnt_t;

    typedef enum logic [1:0] {
        CMD_STORE,
        CMD_ABORT,
        CMD_PICK,
        CMD_EXEC
    } cmd_op_e;

    typedef enum logic [1:0] {
        OP_TRANSPOSE,
        OP_ADD,
        OP_SCALAR_MUL,
        OP_MATMUL
    } calc_op_e;

    typedef enum logic [2:0] {
        ST_OK,
        ST_RANGE,
        ST_FULL,
        ST_NOT_FOUND,
        ST_BAD_ID,
        ST_NO_ALLOC,
        ST_DIM,
        ST_NO_OPERAND
    } status_e;

    typedef struct packed {
        cmd_op_e    op;
        calc_op_e   calc;
        dim_t       dim_m;
        dim_t       dim_n;
        cnt_t       copy_id;
        logic       slot;      // 0 = operand 1, 1 = operand 2
        logic [7:0] scalar;
    } cmd_t;

    typedef struct packed {
        addr_t addr;
        dim_t  dim_m;
        dim_t  dim_n;
    } operand_t;

    typedef struct packed {
        cmd_t     cmd;
        status_e  status;
        operand_t opnd;        // resolved address and dims
    } stage_t;

    typedef struct packed {
        status_e status;
        addr_t   addr;
        dim_t    dim_m;
        dim_t    dim_n;
    } rsp_t;

    typedef struct packed {
        calc_op_e   op;
        operand_t   op1;
        operand_t   op2;
        logic [7:0] scalar;
        addr_t      res_addr;
    } calc_req_t;

endpackage

//--- ledger/ledger_search.sv
module ledger_search #(
    parameter int MAX_TYPES = 25
) (
    input  mcalc_pkg::dim_t  i_dim_m,
    input  mcalc_pkg::dim_t  i_dim_n,
    input  mcalc_pkg::dim_t  i_lut_m     [MAX_TYPES],
    input  mcalc_pkg::dim_t  i_lut_n     [MAX_TYPES],
    input  mcalc_pkg::addr_t i_lut_start [MAX_TYPES],
    input  logic             i_lut_slot  [MAX_TYPES],
    input  mcalc_pkg::idx_t  i_lut_count,
    input  mcalc_pkg::addr_t i_free_ptr,
    output logic             o_found,
    output mcalc_pkg::idx_t  o_index,
    output mcalc_pkg::addr_t o_store_addr
);
    import mcalc_pkg::*;

    addr_t size;

    assign size = addr_t'(i_dim_m) * addr_t'(i_dim_n);

    // last filled entry wins
    always_comb begin
        o_found = 1'b0;
        o_index = '0;
        for (int i = 0; i < MAX_TYPES; i++) begin
            if (i < int'(i_lut_count) && i_lut_m[i] == i_dim_m && i_lut_n[i] == i_dim_n) begin
                o_found = 1'b1;
                o_index = idx_t'(i);
            end
        end
    end

    always_comb begin
        if (!o_found)
            o_store_addr = i_free_ptr;                    // new type
        else if (i_lut_slot[o_index])
            o_store_addr = i_lut_start[o_index] + size;   // upper copy
        else
            o_store_addr = i_lut_start[o_index];
    end

endmodule

//--- ledger/type_ledger.sv
module type_ledger #(
    parameter int MAX_TYPES = 25
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_valid,
    input  mcalc_pkg::stage_t i_item,
    input  logic              i_ready,
    input  mcalc_pkg::dim_t   i_res_dim_m,
    input  mcalc_pkg::dim_t   i_res_dim_n,
    input  logic              i_res_commit,
    output logic              o_ready,
    output logic              o_valid,
    output mcalc_pkg::stage_t o_item,
    output mcalc_pkg::addr_t  o_res_addr,
    output mcalc_pkg::idx_t   o_type_count,
    output logic [7:0]        o_total_count
);
    import mcalc_pkg::*;

    dim_t   lut_m     [MAX_TYPES];
    dim_t   lut_n     [MAX_TYPES];
    addr_t  lut_start [MAX_TYPES];
    logic   lut_slot  [MAX_TYPES];
    cnt_t   lut_cnt   [MAX_TYPES];
    idx_t   type_count;
    addr_t  free_ptr;

    // rollback copy of the last store
    logic   bk_valid;
    logic   bk_new;
    idx_t   bk_idx;
    logic   bk_slot;
    cnt_t   bk_cnt;
    addr_t  bk_ptr;

    logic   cmd_found;
    idx_t   cmd_idx;
    addr_t  cmd_addr;
    addr_t  cmd_size;
    logic   res_found;
    idx_t   res_idx;
    logic   has_room;
    logic   take;
    logic   do_store;
    logic   do_abort;
    logic   upd_en;
    logic   upd_found;
    idx_t   upd_idx;
    dim_t   upd_m;
    dim_t   upd_n;
    addr_t  upd_size;
    stage_t nxt;

    ledger_search #(
        .MAX_TYPES(MAX_TYPES)
    ) u_cmd_search (
        .i_dim_m      (i_item.cmd.dim_m),
        .i_dim_n      (i_item.cmd.dim_n),
        .i_lut_m      (lut_m),
        .i_lut_n      (lut_n),
        .i_lut_start  (lut_start),
        .i_lut_slot   (lut_slot),
        .i_lut_count  (type_count),
        .i_free_ptr   (free_ptr),
        .o_found      (cmd_found),
        .o_index      (cmd_idx),
        .o_store_addr (cmd_addr)
    );

    ledger_search #(
        .MAX_TYPES(MAX_TYPES)
    ) u_res_search (
        .i_dim_m      (i_res_dim_m),
        .i_dim_n      (i_res_dim_n),
        .i_lut_m      (lut_m),
        .i_lut_n      (lut_n),
        .i_lut_start  (lut_start),
        .i_lut_slot   (lut_slot),
        .i_lut_count  (type_count),
        .i_free_ptr   (free_ptr),
        .o_found      (res_found),
        .o_index      (res_idx),
        .o_store_addr (o_res_addr)
    );

    assign has_room = int'(type_count) < MAX_TYPES;
    assign o_ready  = (!o_valid || i_ready) && !i_res_commit;  // commit owns the ledger
    assign take     = i_valid && o_ready;
    assign cmd_size = addr_t'(i_item.cmd.dim_m) * addr_t'(i_item.cmd.dim_n);

    // ==================================================================
    // command handling
    // ==================================================================
    always_comb begin
        nxt      = i_item;
        do_store = 1'b0;
        do_abort = 1'b0;
        if (take && i_item.status == ST_OK) begin
            case (i_item.cmd.op)
                CMD_STORE: begin
                    if (cmd_found || has_room) begin
                        do_store      = 1'b1;
                        nxt.opnd.addr = cmd_addr;
                    end else begin
                        nxt.status = ST_FULL;
                    end
                end
                CMD_ABORT: begin
                    if (bk_valid)
                        do_abort = 1'b1;
                    else
                        nxt.status = ST_NO_ALLOC;
                end
                CMD_PICK: begin
                    if (!cmd_found)
                        nxt.status = ST_NOT_FOUND;
                    else if (i_item.cmd.copy_id == '0 || i_item.cmd.copy_id > lut_cnt[cmd_idx])
                        nxt.status = ST_BAD_ID;
                    else
                        nxt.opnd.addr = lut_start[cmd_idx] +
                                        ((i_item.cmd.copy_id == 2'd2) ? cmd_size : '0);
                end
                default: ;   // exec goes through as is
            endcase
        end
    end

    // store and result commit share one update path
    always_comb begin
        if (i_res_commit) begin
            upd_en    = res_found || has_room;
            upd_found = res_found;
            upd_idx   = res_idx;
            upd_m     = i_res_dim_m;
            upd_n     = i_res_dim_n;
        end else begin
            upd_en    = do_store;
            upd_found = cmd_found;
            upd_idx   = cmd_idx;
            upd_m     = i_item.cmd.dim_m;
            upd_n     = i_item.cmd.dim_n;
        end
    end

    assign upd_size = addr_t'(upd_m) * addr_t'(upd_n);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid    <= 1'b0;
            type_count <= '0;
            free_ptr   <= '0;
            bk_valid   <= 1'b0;
        end else begin
            if (take)
                o_valid <= 1'b1;
            else if (i_ready)
                o_valid <= 1'b0;
            if (take || i_res_commit)
                bk_valid <= do_store;
            if (upd_en && !upd_found) begin
                type_count <= type_count + idx_t'(1);
                free_ptr   <= free_ptr + (upd_size << 1);  // room for two copies
            end
            if (do_abort && bk_new) begin
                type_count <= type_count - idx_t'(1);
                free_ptr   <= bk_ptr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            o_item <= nxt;
        if (do_store) begin
            bk_new  <= !cmd_found;
            bk_idx  <= cmd_idx;
            bk_slot <= lut_slot[cmd_idx];
            bk_cnt  <= lut_cnt[cmd_idx];
            bk_ptr  <= free_ptr;
        end
        if (upd_en && upd_found) begin
            lut_slot[upd_idx] <= !lut_slot[upd_idx];
            if (lut_cnt[upd_idx] != 2'd2)
                lut_cnt[upd_idx] <= lut_cnt[upd_idx] + cnt_t'(1);
        end else if (upd_en) begin
            lut_m[type_count]     <= upd_m;
            lut_n[type_count]     <= upd_n;
            lut_start[type_count] <= free_ptr;
            lut_slot[type_count]  <= 1'b1;
            lut_cnt[type_count]   <= 2'd1;
        end
        if (do_abort && !bk_new) begin
            lut_slot[bk_idx] <= bk_slot;
            lut_cnt[bk_idx]  <= bk_cnt;
        end
    end

    always_comb begin
        o_total_count = '0;
        for (int i = 0; i < MAX_TYPES; i++) begin
            if (i < int'(type_count))
                o_total_count = o_total_count + 8'(lut_cnt[i]);
        end
    end

    assign o_type_count = type_count;

    assert property (@(posedge clk) disable iff (!rst_n)
        int'(type_count) <= MAX_TYPES);

endmodule

//--- verilog/cmd_decode.sv
module cmd_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_cmd_valid,
    input  mcalc_pkg::cmd_t   i_cmd,
    input  logic              i_ready,
    output logic              o_cmd_ready,
    output logic              o_valid,
    output mcalc_pkg::stage_t o_item
);
    import mcalc_pkg::*;

    logic   take;
    logic   need_dims;
    logic   dims_bad;
    stage_t item_d;

    assign o_cmd_ready = !o_valid || i_ready;
    assign take        = i_cmd_valid && o_cmd_ready;

    // only store and pick carry dimensions
    assign need_dims = (i_cmd.op == CMD_STORE) || (i_cmd.op == CMD_PICK);
    assign dims_bad  = (i_cmd.dim_m == '0) || (i_cmd.dim_m > dim_t'(MAX_DIM)) ||
                       (i_cmd.dim_n == '0) || (i_cmd.dim_n > dim_t'(MAX_DIM));

    always_comb begin
        item_d            = '0;
        item_d.cmd        = i_cmd;
        item_d.status     = (need_dims && dims_bad) ? ST_RANGE : ST_OK;
        item_d.opnd.dim_m = i_cmd.dim_m;
        item_d.opnd.dim_n = i_cmd.dim_n;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
        end else if (take) begin
            o_valid <= 1'b1;
        end else if (i_ready) begin
            o_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            o_item <= item_d;
    end

    // a stalled command has to be held by the sender
    assert property (@(posedge clk) disable iff (!rst_n)
        i_cmd_valid && !o_cmd_ready |=> $stable(i_cmd));

endmodule

//--- verilog/op_sequencer.sv
module op_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_valid,
    input  mcalc_pkg::stage_t    i_item,
    input  logic                 i_rsp_ready,
    input  logic                 i_calc_done,
    input  mcalc_pkg::addr_t     i_res_addr,
    output logic                 o_ready,
    output logic                 o_rsp_valid,
    output mcalc_pkg::rsp_t      o_rsp,
    output logic                 o_calc_start,
    output mcalc_pkg::calc_req_t o_calc,
    output mcalc_pkg::dim_t      o_res_dim_m,
    output mcalc_pkg::dim_t      o_res_dim_n,
    output logic                 o_res_commit
);
    import mcalc_pkg::*;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_BUSY,
        SEQ_RESP
    } seq_state_e;

    seq_state_e state;
    operand_t   op1;
    operand_t   op2;
    logic       have1;
    logic       have2;
    logic       take;
    logic       is_pick;
    logic       is_exec;
    logic       issue;
    calc_op_e   calc_sel;
    status_e    chk;

    assign o_ready = (state == SEQ_IDLE && !o_calc_start) ||
                     (state == SEQ_RESP && i_rsp_ready);
    assign take    = i_valid && o_ready;
    assign is_pick = i_item.cmd.op == CMD_PICK && i_item.status == ST_OK;
    assign is_exec = i_item.cmd.op == CMD_EXEC && i_item.status == ST_OK;
    assign issue   = take && is_exec && chk == ST_OK;

    assign o_rsp_valid  = state == SEQ_RESP;
    assign o_res_commit = state == SEQ_BUSY && i_calc_done;

    // held op while the core runs
    assign calc_sel = (state == SEQ_BUSY) ? o_calc.op : i_item.cmd.calc;

    // ==================================================================
    // operand check and result shape
    // ==================================================================
    always_comb begin
        chk = ST_OK;
        if (!have1 || ((calc_sel == OP_ADD || calc_sel == OP_MATMUL) && !have2))
            chk = ST_NO_OPERAND;
        else if (calc_sel == OP_ADD && (op1.dim_m != op2.dim_m || op1.dim_n != op2.dim_n))
            chk = ST_DIM;
        else if (calc_sel == OP_MATMUL && op1.dim_n != op2.dim_m)
            chk = ST_DIM;
    end

    always_comb begin
        o_res_dim_m = op1.dim_m;
        o_res_dim_n = op1.dim_n;
        case (calc_sel)
            OP_TRANSPOSE: begin
                o_res_dim_m = op1.dim_n;
                o_res_dim_n = op1.dim_m;
            end
            OP_MATMUL: o_res_dim_n = op2.dim_n;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= SEQ_IDLE;
            o_calc_start <= 1'b0;
            have1        <= 1'b0;
            have2        <= 1'b0;
        end else begin
            o_calc_start <= issue;
            if (take && is_pick && i_item.cmd.slot)
                have2 <= 1'b1;
            else if (take && is_pick)
                have1 <= 1'b1;
            if (o_calc_start)
                state <= SEQ_BUSY;
            else if (state == SEQ_BUSY) begin
                if (i_calc_done)
                    state <= SEQ_RESP;
            end else if (take)
                state <= issue ? SEQ_IDLE : SEQ_RESP;
            else if (state == SEQ_RESP && i_rsp_ready)
                state <= SEQ_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (take && is_pick && i_item.cmd.slot)
            op2 <= i_item.opnd;
        else if (take && is_pick)
            op1 <= i_item.opnd;
        if (issue) begin
            o_calc.op       <= i_item.cmd.calc;
            o_calc.op1      <= op1;
            o_calc.op2      <= op2;
            o_calc.scalar   <= i_item.cmd.scalar;
            o_calc.res_addr <= i_res_addr;
        end
        if (o_res_commit) begin
            o_rsp.status <= ST_OK;
            o_rsp.addr   <= o_calc.res_addr;
            o_rsp.dim_m  <= o_res_dim_m;
            o_rsp.dim_n  <= o_res_dim_n;
        end else if (take) begin
            o_rsp.status <= is_exec ? chk : i_item.status;
            o_rsp.addr   <= i_item.opnd.addr;
            o_rsp.dim_m  <= i_item.opnd.dim_m;
            o_rsp.dim_n  <= i_item.opnd.dim_n;
        end
    end

    // one operation at a time on the core
    assert property (@(posedge clk) disable iff (!rst_n)
        o_calc_start |-> state != SEQ_BUSY);

endmodule

//--- verilog/mcalc_top.sv
module mcalc_top #(
    parameter int MAX_TYPES = 25
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_cmd_valid,
    input  mcalc_pkg::cmd_t      i_cmd,
    output logic                 o_cmd_ready,
    output logic                 o_rsp_valid,
    output mcalc_pkg::rsp_t      o_rsp,
    input  logic                 i_rsp_ready,
    output logic                 o_calc_start,
    output mcalc_pkg::calc_req_t o_calc,
    input  logic                 i_calc_done,
    output mcalc_pkg::idx_t      o_type_count,
    output logic [7:0]           o_total_count
);
    import mcalc_pkg::*;

    logic   dec_valid;
    logic   dec_ready;
    stage_t dec_item;
    logic   lgr_valid;
    logic   lgr_ready;
    stage_t lgr_item;
    dim_t   res_dim_m;
    dim_t   res_dim_n;
    addr_t  res_addr;
    logic   res_commit;

    cmd_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd       (i_cmd),
        .i_ready     (dec_ready),
        .o_cmd_ready (o_cmd_ready),
        .o_valid     (dec_valid),
        .o_item      (dec_item)
    );

    type_ledger #(
        .MAX_TYPES(MAX_TYPES)
    ) u_ledger (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_valid       (dec_valid),
        .i_item        (dec_item),
        .i_ready       (lgr_ready),
        .i_res_dim_m   (res_dim_m),
        .i_res_dim_n   (res_dim_n),
        .i_res_commit  (res_commit),
        .o_ready       (dec_ready),
        .o_valid       (lgr_valid),
        .o_item        (lgr_item),
        .o_res_addr    (res_addr),
        .o_type_count  (o_type_count),
        .o_total_count (o_total_count)
    );

    op_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_valid      (lgr_valid),
        .i_item       (lgr_item),
        .i_rsp_ready  (i_rsp_ready),
        .i_calc_done  (i_calc_done),
        .i_res_addr   (res_addr),
        .o_ready      (lgr_ready),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp        (o_rsp),
        .o_calc_start (o_calc_start),
        .o_calc       (o_calc),
        .o_res_dim_m  (res_dim_m),
        .o_res_dim_n  (res_dim_n),
        .o_res_commit (res_commit)
    );

endmodule

//--- bench/tb_mcalc.sv
module tb_mcalc;
    import mcalc_pkg::*;

    typedef struct packed {
        cmd_t       cmd;
        rsp_t       rsp;
        logic       start;      // exec expected to reach the core
        calc_req_t  calc;
        idx_t       types;
        logic [7:0] total;
    } row_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       i_cmd_valid;
    cmd_t       i_cmd;
    logic       o_cmd_ready;
    logic       o_rsp_valid;
    rsp_t       o_rsp;
    logic       i_rsp_ready;
    logic       o_calc_start;
    calc_req_t  o_calc;
    logic       i_calc_done;
    idx_t       o_type_count;
    logic [7:0] o_total_count;

    row_t        rows[$];
    logic        table_ready = 1'b0;
    calc_req_t   exp_calc;
    int          starts = 0;
    logic [15:0] lfsr = 16'd23521;

    mcalc_top #(
        .MAX_TYPES(25)
    ) dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_cmd_valid   (i_cmd_valid),
        .i_cmd         (i_cmd),
        .o_cmd_ready   (o_cmd_ready),
        .o_rsp_valid   (o_rsp_valid),
        .o_rsp         (o_rsp),
        .i_rsp_ready   (i_rsp_ready),
        .o_calc_start  (o_calc_start),
        .o_calc        (o_calc),
        .i_calc_done   (i_calc_done),
        .o_type_count  (o_type_count),
        .o_total_count (o_total_count)
    );

    always #5 clk = ~clk;

    // ======================================================================
    // helpers
    // ======================================================================
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic cmd_t mk_cmd(input cmd_op_e op, input calc_op_e calc, input int m,
                                    input int n, input int copy, input logic slot,
                                    input logic [7:0] scalar);
        cmd_t c;
        c.op      = op;
        c.calc    = calc;
        c.dim_m   = dim_t'(m);
        c.dim_n   = dim_t'(n);
        c.copy_id = cnt_t'(copy);
        c.slot    = slot;
        c.scalar  = scalar;
        return c;
    endfunction

    function automatic cmd_t store_cmd(input int m, input int n);
        return mk_cmd(CMD_STORE, OP_TRANSPOSE, m, n, 0, 1'b0, 8'h00);
    endfunction

    function automatic cmd_t abort_cmd();
        return mk_cmd(CMD_ABORT, OP_TRANSPOSE, 0, 0, 0, 1'b0, 8'h00);
    endfunction

    function automatic cmd_t pick_cmd(input int m, input int n, input int copy,
                                      input logic slot);
        return mk_cmd(CMD_PICK, OP_TRANSPOSE, m, n, copy, slot, 8'h00);
    endfunction

    function automatic cmd_t exec_cmd(input calc_op_e op, input logic [7:0] scalar);
        return mk_cmd(CMD_EXEC, op, 0, 0, 0, 1'b0, scalar);
    endfunction

    function automatic rsp_t mk_rsp(input status_e st, input int addr, input int m, input int n);
        rsp_t r;
        r.status = st;
        r.addr   = addr_t'(addr);
        r.dim_m  = dim_t'(m);
        r.dim_n  = dim_t'(n);
        return r;
    endfunction

    function automatic operand_t mk_opnd(input int addr, input int m, input int n);
        operand_t o;
        o.addr  = addr_t'(addr);
        o.dim_m = dim_t'(m);
        o.dim_n = dim_t'(n);
        return o;
    endfunction

    function automatic calc_req_t mk_calc(input calc_op_e op, input operand_t a,
                                          input operand_t b, input logic [7:0] s,
                                          input int res);
        calc_req_t q;
        q.op       = op;
        q.op1      = a;
        q.op2      = b;
        q.scalar   = s;
        q.res_addr = addr_t'(res);
        return q;
    endfunction

    task automatic expect_rsp(input cmd_t c, input rsp_t r, input int types, input int total);
        row_t w;
        w.cmd   = c;
        w.rsp   = r;
        w.start = 1'b0;
        w.calc  = '0;
        w.types = idx_t'(types);
        w.total = 8'(total);
        rows.push_back(w);
    endtask

    task automatic expect_calc(input cmd_t c, input rsp_t r, input int types, input int total,
                               input calc_req_t q);
        row_t w;
        w.cmd   = c;
        w.rsp   = r;
        w.start = 1'b1;
        w.calc  = q;
        w.types = idx_t'(types);
        w.total = 8'(total);
        rows.push_back(w);
    endtask

    // ======================================================================
    // stimulus table
    // ======================================================================
    task automatic build_table();
        // new types, then wrap of the 2x3 slots
        expect_rsp(store_cmd(2, 3), mk_rsp(ST_OK, 0, 2, 3), 1, 1);
        expect_rsp(store_cmd(3, 3), mk_rsp(ST_OK, 12, 3, 3), 2, 2);
        expect_rsp(store_cmd(1, 4), mk_rsp(ST_OK, 30, 1, 4), 3, 3);
        expect_rsp(store_cmd(2, 3), mk_rsp(ST_OK, 6, 2, 3), 3, 4);
        expect_rsp(store_cmd(2, 3), mk_rsp(ST_OK, 0, 2, 3), 3, 4);
        expect_rsp(store_cmd(2, 3), mk_rsp(ST_OK, 6, 2, 3), 3, 4);
        // abort of new and existing types
        expect_rsp(store_cmd(5, 5), mk_rsp(ST_OK, 38, 5, 5), 4, 5);
        expect_rsp(abort_cmd(), mk_rsp(ST_OK, 0, 0, 0), 3, 4);
        expect_rsp(store_cmd(4, 4), mk_rsp(ST_OK, 38, 4, 4), 4, 5);
        expect_rsp(abort_cmd(), mk_rsp(ST_OK, 0, 0, 0), 3, 4);
        expect_rsp(abort_cmd(), mk_rsp(ST_NO_ALLOC, 0, 0, 0), 3, 4);
        expect_rsp(store_cmd(0, 3), mk_rsp(ST_RANGE, 0, 0, 3), 3, 4);
        expect_rsp(store_cmd(6, 2), mk_rsp(ST_RANGE, 0, 6, 2), 3, 4);
        expect_rsp(store_cmd(3, 3), mk_rsp(ST_OK, 21, 3, 3), 3, 5);
        expect_rsp(abort_cmd(), mk_rsp(ST_OK, 0, 0, 0), 3, 4);
        // picks
        expect_rsp(pick_cmd(4, 4, 1, 1'b0), mk_rsp(ST_NOT_FOUND, 0, 4, 4), 3, 4);
        expect_rsp(pick_cmd(2, 3, 0, 1'b0), mk_rsp(ST_BAD_ID, 0, 2, 3), 3, 4);
        expect_rsp(pick_cmd(2, 3, 3, 1'b0), mk_rsp(ST_BAD_ID, 0, 2, 3), 3, 4);
        expect_rsp(pick_cmd(3, 3, 2, 1'b0), mk_rsp(ST_BAD_ID, 0, 3, 3), 3, 4);
        expect_rsp(exec_cmd(OP_TRANSPOSE, 8'h00), mk_rsp(ST_NO_OPERAND, 0, 0, 0), 3, 4);
        expect_rsp(pick_cmd(2, 3, 2, 1'b0), mk_rsp(ST_OK, 6, 2, 3), 3, 4);
        expect_rsp(exec_cmd(OP_MATMUL, 8'h00), mk_rsp(ST_NO_OPERAND, 0, 0, 0), 3, 4);
        expect_rsp(pick_cmd(3, 3, 1, 1'b1), mk_rsp(ST_OK, 12, 3, 3), 3, 4);
        // executions
        expect_calc(exec_cmd(OP_MATMUL, 8'h11), mk_rsp(ST_OK, 0, 2, 3), 3, 4,
                    mk_calc(OP_MATMUL, mk_opnd(6, 2, 3), mk_opnd(12, 3, 3), 8'h11, 0));
        expect_rsp(exec_cmd(OP_ADD, 8'h00), mk_rsp(ST_DIM, 0, 0, 0), 3, 4);
        expect_calc(exec_cmd(OP_TRANSPOSE, 8'h22), mk_rsp(ST_OK, 38, 3, 2), 4, 5,
                    mk_calc(OP_TRANSPOSE, mk_opnd(6, 2, 3), mk_opnd(12, 3, 3), 8'h22, 38));
        expect_calc(exec_cmd(OP_SCALAR_MUL, 8'h5A), mk_rsp(ST_OK, 6, 2, 3), 4, 5,
                    mk_calc(OP_SCALAR_MUL, mk_opnd(6, 2, 3), mk_opnd(12, 3, 3), 8'h5A, 6));
        expect_rsp(pick_cmd(3, 2, 1, 1'b1), mk_rsp(ST_OK, 38, 3, 2), 4, 5);
        expect_calc(exec_cmd(OP_MATMUL, 8'h33), mk_rsp(ST_OK, 50, 2, 2), 5, 6,
                    mk_calc(OP_MATMUL, mk_opnd(6, 2, 3), mk_opnd(38, 3, 2), 8'h33, 50));
        expect_rsp(pick_cmd(2, 2, 1, 1'b1), mk_rsp(ST_OK, 50, 2, 2), 5, 6);
        expect_rsp(exec_cmd(OP_ADD, 8'h00), mk_rsp(ST_DIM, 0, 0, 0), 5, 6);
        expect_rsp(store_cmd(2, 2), mk_rsp(ST_OK, 54, 2, 2), 5, 7);
        expect_rsp(pick_cmd(2, 2, 2, 1'b0), mk_rsp(ST_OK, 54, 2, 2), 5, 7);
        expect_calc(exec_cmd(OP_ADD, 8'h44), mk_rsp(ST_OK, 50, 2, 2), 5, 7,
                    mk_calc(OP_ADD, mk_opnd(54, 2, 2), mk_opnd(50, 2, 2), 8'h44, 50));
        expect_rsp(abort_cmd(), mk_rsp(ST_NO_ALLOC, 0, 0, 0), 5, 7);   // exec cleared backup
    endtask

    task automatic send_cmd(input cmd_t c);
        @(negedge clk);
        check("o_rsp_valid", 64'(o_rsp_valid), 64'd0);   // no leftover response
        i_cmd       = c;
        i_cmd_valid = 1'b1;
        while (!o_cmd_ready)
            @(negedge clk);
        @(negedge clk);
        i_cmd_valid = 1'b0;
    endtask

    task automatic wait_rsp(input row_t r, input int starts_before);
        int hold;
        hold        = (rand_bits(1) == 1) ? rand_bits(2) + 1 : 0;
        i_rsp_ready = (hold == 0);
        while (!(o_rsp_valid && i_rsp_ready)) begin
            @(negedge clk);
            if (o_rsp_valid && !i_rsp_ready) begin
                hold = hold - 1;
                if (hold == 0)
                    i_rsp_ready = 1'b1;
            end
        end
        check("o_rsp.status", 64'(o_rsp.status), 64'(r.rsp.status));
        check("o_rsp.addr", 64'(o_rsp.addr), 64'(r.rsp.addr));
        check("o_rsp.dim_m", 64'(o_rsp.dim_m), 64'(r.rsp.dim_m));
        check("o_rsp.dim_n", 64'(o_rsp.dim_n), 64'(r.rsp.dim_n));
        check("o_type_count", 64'(o_type_count), 64'(r.types));
        check("o_total_count", 64'(o_total_count), 64'(r.total));
        check("o_calc_start pulses", 64'(starts - starts_before), 64'(r.start));
        @(posedge clk);
    endtask

    // ======================================================================
    // calculator core model
    // ======================================================================
    initial begin
        int delay;
        i_calc_done = 1'b0;
        forever begin
            @(negedge clk);
            if (o_calc_start) begin
                starts = starts + 1;
                check("o_calc", 64'(o_calc), 64'(exp_calc));
                delay = rand_bits(3) + 1;
                repeat (delay) @(negedge clk);
                i_calc_done = 1'b1;
                @(negedge clk);
                i_calc_done = 1'b0;
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (rows.size() * 40) @(posedge clk);
        $display("timeout: the table did not finish within %0d cycles", rows.size() * 40);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        row_t r;
        int   starts_before;
        rst_n       = 1'b0;
        i_cmd_valid = 1'b0;
        i_cmd       = '0;
        i_rsp_ready = 1'b1;
        exp_calc    = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check("o_cmd_ready", 64'(o_cmd_ready), 64'd1);
        check("o_rsp_valid", 64'(o_rsp_valid), 64'd0);
        check("o_calc_start", 64'(o_calc_start), 64'd0);
        check("o_type_count", 64'(o_type_count), 64'd0);

        foreach (rows[i]) begin
            r             = rows[i];
            exp_calc      = r.calc;
            starts_before = starts;
            send_cmd(r.cmd);
            wait_rsp(r, starts_before);
        end

        @(negedge clk);
        check("o_rsp_valid", 64'(o_rsp_valid), 64'd0);
        $display("Test passed");
        $finish;
    end

endmodule

//--- project.f
common/mcalc_pkg.sv
ledger/ledger_search.sv
ledger/type_ledger.sv
verilog/cmd_decode.sv
verilog/op_sequencer.sv
verilog/mcalc_top.sv
bench/tb_mcalc.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mcalc
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
